// ==== verilog/ooo_pkg.sv ====
// default sizes and ALU operation codes shared by the execution core RTL
`default_nettype none

package ooo_pkg;

	// top level defaults, overridden through module parameters
	localparam int XLEN_DEFAULT = 32;
	// must stay a power of two so the pointers wrap on their own
	localparam int ROB_SIZE_DEFAULT = 8;
	localparam int N_ALU_RS_DEFAULT = 3;

	// field widths of a decoded instruction
	localparam int FUNCT3_WIDTH = 3;
	localparam int RD_WIDTH = 5;

	// operation codes in RISC-V funct3 order
	// alt turns ADD into SUB
	localparam logic [FUNCT3_WIDTH-1:0] F3_ADD = 3'b000;
	localparam logic [FUNCT3_WIDTH-1:0] F3_SLL = 3'b001;
	localparam logic [FUNCT3_WIDTH-1:0] F3_SLT = 3'b010;
	localparam logic [FUNCT3_WIDTH-1:0] F3_SLTU = 3'b011;
	localparam logic [FUNCT3_WIDTH-1:0] F3_XOR = 3'b100;
	// alt selects arithmetic right shift
	localparam logic [FUNCT3_WIDTH-1:0] F3_SR = 3'b101;
	localparam logic [FUNCT3_WIDTH-1:0] F3_OR = 3'b110;
	localparam logic [FUNCT3_WIDTH-1:0] F3_AND = 3'b111;

	// shift amount comes from the low bits of operand 2
	localparam int SHAMT_WIDTH = 5;

endpackage

`default_nettype wire

// ==== verilog/issue_route.sv ====
// issue stage, resolves operands, picks a free station, allocates the ROB tail, stalls
`timescale 1ns/1ns
`default_nettype none

module issue_route #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT,
	parameter int N_ALU_RS = ooo_pkg::N_ALU_RS_DEFAULT,
	localparam int TAG_W = $clog2(ROB_SIZE)
) (
	input logic issue,
	input logic src1_pending,
	input logic [TAG_W-1:0] src1_tag,
	input logic [XLEN-1:0] src1_value,
	input logic src2_pending,
	input logic [TAG_W-1:0] src2_tag,
	input logic [XLEN-1:0] src2_value,
	input logic [N_ALU_RS-1:0] rs_busy,
	input logic rob_full,
	input logic [ROB_SIZE-1:0] rob_ready,
	input logic [ROB_SIZE-1:0][XLEN-1:0] rob_value,
	input logic cdb_valid,
	input logic [TAG_W-1:0] cdb_tag,
	input logic [XLEN-1:0] cdb_data,
	output logic [N_ALU_RS-1:0] rs_load,
	output logic rob_alloc,
	output logic op1_pending,
	output logic [TAG_W-1:0] op1_tag,
	output logic [XLEN-1:0] op1_value,
	output logic op2_pending,
	output logic [TAG_W-1:0] op2_tag,
	output logic [XLEN-1:0] op2_value,
	output logic stall
);

	logic [N_ALU_RS-1:0] rs_pick;
	logic rs_found;
	logic accepted;

	// {still pending, value}, ROB result first, then same-cycle CDB forward
	function automatic logic [XLEN:0] resolve(input logic pending,
			input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] value);
		logic [XLEN:0] r;
		r = {1'b0, value};
		if (pending) begin
			if (rob_ready[tag])
				r = {1'b0, rob_value[tag]};
			else if (cdb_valid && cdb_tag == tag)
				r = {1'b0, cdb_data};
			else
				r = {1'b1, value};
		end
		return r;
	endfunction

	// tags pass straight through, only meaningful while pending
	assign op1_tag = src1_tag;
	assign op2_tag = src2_tag;

	always_comb begin
		{op1_pending, op1_value} = resolve(src1_pending, src1_tag, src1_value);
		{op2_pending, op2_value} = resolve(src2_pending, src2_tag, src2_value);
	end

	// lowest numbered free station
	always_comb begin
		rs_pick = '0;
		rs_found = 1'b0;
		for (int i = 0; i < N_ALU_RS; i++) begin
			if (!rs_busy[i] && !rs_found) begin
				rs_pick[i] = 1'b1;
				rs_found = 1'b1;
			end
		end
	end

	// stall is a level, independent of issue
	assign stall = !rs_found || rob_full;
	assign accepted = issue && !stall;

	assign rs_load = accepted ? rs_pick : '0;
	assign rob_alloc = accepted;

endmodule

`default_nettype wire

// ==== verilog/reservation_station.sv ====
// ALU reservation station, waits on the CDB for operands and for its own result
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT,
	localparam int TAG_W = $clog2(ROB_SIZE)
) (
	input logic clk,
	input logic reset,
	input logic load,
	input logic op1_pending,
	input logic [TAG_W-1:0] op1_tag,
	input logic [XLEN-1:0] op1_value,
	input logic op2_pending,
	input logic [TAG_W-1:0] op2_tag,
	input logic [XLEN-1:0] op2_value,
	input logic [ooo_pkg::FUNCT3_WIDTH-1:0] funct3,
	input logic alt,
	input logic [TAG_W-1:0] rob_tag,
	input logic cdb_valid,
	input logic [TAG_W-1:0] cdb_tag,
	input logic [XLEN-1:0] cdb_data,
	input logic accept,
	output logic busy,
	output logic ready,
	output logic [XLEN-1:0] v1,
	output logic [XLEN-1:0] v2,
	output logic [ooo_pkg::FUNCT3_WIDTH-1:0] funct3_out,
	output logic alt_out,
	output logic [TAG_W-1:0] tag_out
);

	// handed to the unit, now waiting for our own broadcast
	logic dispatched;
	logic q1_pending;
	logic q2_pending;
	logic [TAG_W-1:0] q1;
	logic [TAG_W-1:0] q2;
	logic own_broadcast;

	assign own_broadcast = cdb_valid && cdb_tag == tag_out;
	assign ready = busy && !dispatched && !q1_pending && !q2_pending;

	// occupancy and dispatch state
	always_ff @(posedge clk) begin
		if (!reset) begin
			busy <= 1'b0;
			dispatched <= 1'b0;
		end else if (load) begin
			busy <= 1'b1;
			dispatched <= 1'b0;
		end else if (busy && dispatched && own_broadcast) begin
			// result is on the bus, slot is free from next cycle
			busy <= 1'b0;
			dispatched <= 1'b0;
		end else if (accept) begin
			dispatched <= 1'b1;
		end
	end

	// payload, captured on load and patched by CDB snooping
	always_ff @(posedge clk) begin
		if (load) begin
			q1_pending <= op1_pending;
			q1 <= op1_tag;
			v1 <= op1_value;
			q2_pending <= op2_pending;
			q2 <= op2_tag;
			v2 <= op2_value;
			funct3_out <= funct3;
			alt_out <= alt;
			tag_out <= rob_tag;
		end else if (busy) begin
			if (q1_pending && cdb_valid && cdb_tag == q1) begin
				v1 <= cdb_data;
				q1_pending <= 1'b0;
			end
			// both operands may wait on the same producer
			if (q2_pending && cdb_valid && cdb_tag == q2) begin
				v2 <= cdb_data;
				q2_pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/alu_unit.sv ====
// ALU functional unit with a one-entry result register that requests the CDB
`timescale 1ns/1ns
`default_nettype none

module alu_unit #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT,
	localparam int TAG_W = $clog2(ROB_SIZE)
) (
	input logic clk,
	input logic reset,
	input logic ready,
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b,
	input logic [ooo_pkg::FUNCT3_WIDTH-1:0] funct3,
	input logic alt,
	input logic [TAG_W-1:0] tag_in,
	input logic grant,
	output logic accept,
	output logic request,
	output logic [XLEN-1:0] result,
	output logic [TAG_W-1:0] tag_out
);

	logic full;
	logic [ooo_pkg::SHAMT_WIDTH-1:0] shamt;
	logic [XLEN-1:0] alu_out;

	assign shamt = b[ooo_pkg::SHAMT_WIDTH-1:0];

	always_comb begin
		case (funct3)
			ooo_pkg::F3_ADD: alu_out = alt ? a - b : a + b;
			ooo_pkg::F3_SLL: alu_out = a << shamt;
			ooo_pkg::F3_SLT: alu_out = XLEN'($signed(a) < $signed(b));
			ooo_pkg::F3_SLTU: alu_out = XLEN'(a < b);
			ooo_pkg::F3_XOR: alu_out = a ^ b;
			// sign fill only when alt is set
			ooo_pkg::F3_SR: alu_out = alt ? XLEN'($signed(a) >>> shamt) : a >> shamt;
			ooo_pkg::F3_OR: alu_out = a | b;
			default: alu_out = a & b;
		endcase
	end

	// one instruction in flight, nothing new until the result leaves
	assign accept = ready && !full;
	assign request = full;

	always_ff @(posedge clk) begin
		if (!reset)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
		else if (grant)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result <= alu_out;
			tag_out <= tag_in;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/common_data_bus.sv ====
// CDB, fixed-priority arbiter over the ALU units and mux of the granted result
`timescale 1ns/1ns
`default_nettype none

module common_data_bus #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT,
	parameter int N_ALU_RS = ooo_pkg::N_ALU_RS_DEFAULT,
	localparam int TAG_W = $clog2(ROB_SIZE)
) (
	input logic [N_ALU_RS-1:0] request,
	input logic [N_ALU_RS-1:0][XLEN-1:0] result,
	input logic [N_ALU_RS-1:0][TAG_W-1:0] tag,
	output logic [N_ALU_RS-1:0] grant,
	output logic cdb_valid,
	output logic [TAG_W-1:0] cdb_tag,
	output logic [XLEN-1:0] cdb_data
);

	// lowest index first, the bus carries zeros when idle
	always_comb begin
		grant = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		for (int i = 0; i < N_ALU_RS; i++) begin
			if (request[i] && !cdb_valid) begin
				grant[i] = 1'b1;
				cdb_valid = 1'b1;
				cdb_tag = tag[i];
				cdb_data = result[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
// reorder buffer, records CDB results and commits them in program order
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT,
	localparam int TAG_W = $clog2(ROB_SIZE)
) (
	input logic clk,
	input logic reset,
	input logic alloc,
	input logic [ooo_pkg::RD_WIDTH-1:0] rd,
	input logic cdb_valid,
	input logic [TAG_W-1:0] cdb_tag,
	input logic [XLEN-1:0] cdb_data,
	output logic [TAG_W-1:0] tail,
	output logic full,
	output logic [ROB_SIZE-1:0] ready,
	output logic [ROB_SIZE-1:0][XLEN-1:0] value,
	output logic commit_valid,
	output logic [ooo_pkg::RD_WIDTH-1:0] commit_rd,
	output logic [XLEN-1:0] commit_value
);

	logic [ROB_SIZE-1:0] valid;
	logic [ROB_SIZE-1:0][ooo_pkg::RD_WIDTH-1:0] dest;
	logic [TAG_W-1:0] head;
	// one bit wider so a full buffer is distinct from an empty one
	logic [TAG_W:0] count;

	assign full = count == (TAG_W+1)'(ROB_SIZE);

	// head is visible combinationally, it retires at this edge
	assign commit_valid = valid[head] && ready[head];
	assign commit_rd = dest[head];
	assign commit_value = value[head];

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (alloc)
				tail <= tail + 1'b1;
			if (commit_valid)
				head <= head + 1'b1;
			// both at once leave the count unchanged
			if (alloc && !commit_valid)
				count <= count + 1'b1;
			else if (!alloc && commit_valid)
				count <= count - 1'b1;
		end
	end

	// per-entry status bits
	always_ff @(posedge clk) begin
		if (!reset) begin
			valid <= '0;
			ready <= '0;
		end else begin
			if (commit_valid)
				valid[head] <= 1'b0;
			if (cdb_valid)
				ready[cdb_tag] <= 1'b1;
			// ready stays up after commit until the slot is reused
			if (alloc) begin
				valid[tail] <= 1'b1;
				ready[tail] <= 1'b0;
			end
		end
	end

	// destination and result storage
	always_ff @(posedge clk) begin
		if (alloc)
			dest[tail] <= rd;
		if (cdb_valid)
			value[cdb_tag] <= cdb_data;
	end

endmodule

`default_nettype wire

// ==== verilog/alu_core.sv ====
// top level of the out-of-order ALU core, issue in, commits out in program order
`timescale 1ns/1ns
`default_nettype none

module alu_core #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT,
	parameter int N_ALU_RS = ooo_pkg::N_ALU_RS_DEFAULT,
	localparam int TAG_W = $clog2(ROB_SIZE)
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic [ooo_pkg::FUNCT3_WIDTH-1:0] funct3,
	input logic alt,
	input logic [ooo_pkg::RD_WIDTH-1:0] rd,
	input logic src1_pending,
	input logic src2_pending,
	input logic [TAG_W-1:0] src1_tag,
	input logic [TAG_W-1:0] src2_tag,
	input logic [XLEN-1:0] src1_value,
	input logic [XLEN-1:0] src2_value,
	output logic stall,
	output logic commit_valid,
	output logic [ooo_pkg::RD_WIDTH-1:0] commit_rd,
	output logic [XLEN-1:0] commit_value
);

	// resolved operands heading into the stations
	logic op1_pending;
	logic op2_pending;
	logic [TAG_W-1:0] op1_tag;
	logic [TAG_W-1:0] op2_tag;
	logic [XLEN-1:0] op1_value;
	logic [XLEN-1:0] op2_value;

	// station side, one bit or word per station
	logic [N_ALU_RS-1:0] rs_busy;
	logic [N_ALU_RS-1:0] rs_load;
	logic [N_ALU_RS-1:0] rs_ready;
	logic [N_ALU_RS-1:0] rs_accept;
	logic [N_ALU_RS-1:0][XLEN-1:0] rs_v1;
	logic [N_ALU_RS-1:0][XLEN-1:0] rs_v2;
	logic [N_ALU_RS-1:0][ooo_pkg::FUNCT3_WIDTH-1:0] rs_funct3;
	logic [N_ALU_RS-1:0] rs_alt;
	logic [N_ALU_RS-1:0][TAG_W-1:0] rs_tag;

	// unit outputs toward the CDB arbiter
	logic [N_ALU_RS-1:0] fu_request;
	logic [N_ALU_RS-1:0] fu_grant;
	logic [N_ALU_RS-1:0][XLEN-1:0] fu_result;
	logic [N_ALU_RS-1:0][TAG_W-1:0] fu_tag;

	// CDB
	logic cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	logic [XLEN-1:0] cdb_data;

	// reorder buffer
	logic rob_alloc;
	logic rob_full;
	logic [TAG_W-1:0] rob_tail;
	logic [ROB_SIZE-1:0] rob_ready;
	logic [ROB_SIZE-1:0][XLEN-1:0] rob_value;

	issue_route #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE), .N_ALU_RS(N_ALU_RS)) issue_route (
		.issue(issue),
		.src1_pending(src1_pending),
		.src1_tag(src1_tag),
		.src1_value(src1_value),
		.src2_pending(src2_pending),
		.src2_tag(src2_tag),
		.src2_value(src2_value),
		.rs_busy(rs_busy),
		.rob_full(rob_full),
		.rob_ready(rob_ready),
		.rob_value(rob_value),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.rs_load(rs_load),
		.rob_alloc(rob_alloc),
		.op1_pending(op1_pending),
		.op1_tag(op1_tag),
		.op1_value(op1_value),
		.op2_pending(op2_pending),
		.op2_tag(op2_tag),
		.op2_value(op2_value),
		.stall(stall)
	);

	// one station feeding one ALU unit, lowest index wins the CDB
	for (genvar i = 0; i < N_ALU_RS; i++) begin : g_alu
		reservation_station #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE)) alu_rs (
			.clk(clk),
			.reset(reset),
			.load(rs_load[i]),
			.op1_pending(op1_pending),
			.op1_tag(op1_tag),
			.op1_value(op1_value),
			.op2_pending(op2_pending),
			.op2_tag(op2_tag),
			.op2_value(op2_value),
			.funct3(funct3),
			.alt(alt),
			.rob_tag(rob_tail),
			.cdb_valid(cdb_valid),
			.cdb_tag(cdb_tag),
			.cdb_data(cdb_data),
			.accept(rs_accept[i]),
			.busy(rs_busy[i]),
			.ready(rs_ready[i]),
			.v1(rs_v1[i]),
			.v2(rs_v2[i]),
			.funct3_out(rs_funct3[i]),
			.alt_out(rs_alt[i]),
			.tag_out(rs_tag[i])
		);

		alu_unit #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE)) alu (
			.clk(clk),
			.reset(reset),
			.ready(rs_ready[i]),
			.a(rs_v1[i]),
			.b(rs_v2[i]),
			.funct3(rs_funct3[i]),
			.alt(rs_alt[i]),
			.tag_in(rs_tag[i]),
			.grant(fu_grant[i]),
			.accept(rs_accept[i]),
			.request(fu_request[i]),
			.result(fu_result[i]),
			.tag_out(fu_tag[i])
		);
	end

	common_data_bus #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE), .N_ALU_RS(N_ALU_RS)) cdb (
		.request(fu_request),
		.result(fu_result),
		.tag(fu_tag),
		.grant(fu_grant),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data)
	);

	reorder_buffer #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE)) rob (
		.clk(clk),
		.reset(reset),
		.alloc(rob_alloc),
		.rd(rd),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.tail(rob_tail),
		.full(rob_full),
		.ready(rob_ready),
		.value(rob_value),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_value(commit_value)
	);

endmodule

`default_nettype wire

// ==== test/alu_core_assertions.sv ====
// concurrent checks of reset state and port protocol, bound into every alu_core instance
`timescale 1ns/1ns
`default_nettype none

module alu_core_assertions #(
	parameter int XLEN = ooo_pkg::XLEN_DEFAULT,
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic commit_valid,
	input logic [ooo_pkg::RD_WIDTH-1:0] commit_rd,
	input logic [XLEN-1:0] commit_value
);

	// longest stall before the pipeline counts as stuck
	localparam int STALL_LIMIT = 4 * ROB_SIZE;

	// read by the testbench at the end of the run
	int unsigned fail_count = 0;

	// empty core right after a reset cycle
	reset_state: assert property (@(posedge clk) !reset |=> !stall && !commit_valid)
		else begin
			fail_count++;
			$error("stall or commit_valid high in the cycle after reset");
		end

	commit_known: assert property (@(posedge clk) disable iff (!reset)
			commit_valid |-> !$isunknown({commit_rd, commit_value}))
		else begin
			fail_count++;
			$error("commit_rd or commit_value unknown during a commit");
		end

	// stations and reorder buffer must drain
	stall_bounded: assert property (@(posedge clk) disable iff (!reset)
			$rose(stall) |-> ##[1:STALL_LIMIT] !stall)
		else begin
			fail_count++;
			$error("stall held longer than %0d cycles", STALL_LIMIT);
		end

endmodule

bind alu_core alu_core_assertions #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE)) protocol_checks (
	.clk(clk),
	.reset(reset),
	.stall(stall),
	.commit_valid(commit_valid),
	.commit_rd(commit_rd),
	.commit_value(commit_value)
);

`default_nettype wire

// ==== test/alu_core_tb.sv ====
// testbench for the ALU core, replays the stim file through issue and checks every commit
`timescale 1ns/1ns
`default_nettype none

module alu_core_tb;

	localparam int XLEN = ooo_pkg::XLEN_DEFAULT;
	localparam int ROB_SIZE = ooo_pkg::ROB_SIZE_DEFAULT;
	localparam int N_ALU_RS = ooo_pkg::N_ALU_RS_DEFAULT;
	localparam int TAG_W = $clog2(ROB_SIZE);
	localparam int F3_W = ooo_pkg::FUNCT3_WIDTH;
	localparam int RD_W = ooo_pkg::RD_WIDTH;
	localparam int MAX_LINES = 64;

	// columns of one stim line, one word each
	localparam int FIELDS = 8;
	localparam int COL_FUNCT3 = 0;
	localparam int COL_ALT = 1;
	localparam int COL_RD = 2;
	// a source is a kind word followed by an immediate or a line index
	localparam int COL_SRC1 = 3;
	localparam int COL_SRC2 = 5;
	localparam int COL_EXPECT = 7;

	logic clk = 1'b0;
	logic reset;
	logic issue;
	logic [ooo_pkg::FUNCT3_WIDTH-1:0] funct3;
	logic alt;
	logic [ooo_pkg::RD_WIDTH-1:0] rd;
	logic src1_pending;
	logic src2_pending;
	logic [TAG_W-1:0] src1_tag;
	logic [TAG_W-1:0] src2_tag;
	logic [XLEN-1:0] src1_value;
	logic [XLEN-1:0] src2_value;
	logic stall;
	logic commit_valid;
	logic [ooo_pkg::RD_WIDTH-1:0] commit_rd;
	logic [XLEN-1:0] commit_value;

	logic [XLEN-1:0] stim [0:MAX_LINES*FIELDS-1];
	int line_count = 0;
	// issued counts lines the core has taken, committed the ones seen retiring
	int issued = 0;
	int committed = 0;
	int value_errors = 0;
	int other_errors = 0;
	// set once the core has held back an issue
	logic stall_seen = 1'b0;

	alu_core #(.XLEN(XLEN), .ROB_SIZE(ROB_SIZE), .N_ALU_RS(N_ALU_RS)) UUT (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.funct3(funct3),
		.alt(alt),
		.rd(rd),
		.src1_pending(src1_pending),
		.src2_pending(src2_pending),
		.src1_tag(src1_tag),
		.src2_tag(src2_tag),
		.src1_value(src1_value),
		.src2_value(src2_value),
		.stall(stall),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_value(commit_value)
	);

	always #50 clk = ~clk;

	function automatic logic [XLEN-1:0] field(input int line, input int col);
		return stim[line*FIELDS+col];
	endfunction

	// a source naming a retired line goes in as a value, otherwise as that line's tag
	task automatic source_for(input int line, input int col, output logic pending,
			output logic [TAG_W-1:0] tag, output logic [XLEN-1:0] value);
		int producer;
		producer = 0;
		pending = 1'b0;
		tag = '0;
		value = field(line, col + 1);
		if (field(line, col) != 0) begin
			producer = int'(field(line, col + 1));
			value = '0;
			if (producer < committed)
				value = field(producer, COL_EXPECT);
			else begin
				pending = 1'b1;
				tag = TAG_W'(producer % ROB_SIZE);
			end
		end
	endtask

	task automatic drive_line(input int line);
		logic p1;
		logic p2;
		logic [TAG_W-1:0] t1;
		logic [TAG_W-1:0] t2;
		logic [XLEN-1:0] v1;
		logic [XLEN-1:0] v2;
		source_for(line, COL_SRC1, p1, t1, v1);
		source_for(line, COL_SRC2, p2, t2, v2);
		issue = 1'b1;
		funct3 = F3_W'(field(line, COL_FUNCT3));
		alt = field(line, COL_ALT) != 0;
		rd = RD_W'(field(line, COL_RD));
		src1_pending = p1;
		src1_tag = t1;
		src1_value = v1;
		src2_pending = p2;
		src2_tag = t2;
		src2_value = v2;
	endtask

	task automatic hold_idle();
		issue = 1'b0;
		funct3 = '0;
		alt = 1'b0;
		rd = '0;
		src1_pending = 1'b0;
		src2_pending = 1'b0;
		src1_tag = '0;
		src2_tag = '0;
		src1_value = '0;
		src2_value = '0;
	endtask

	task automatic check_rd(input int line, input logic [ooo_pkg::RD_WIDTH-1:0] got,
			input logic [ooo_pkg::RD_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] commit_rd line %0d: got %h expected %h", line, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_value(input int line, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] commit_value line %0d: got %h expected %h", line, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] stall: got %h expected %h", got, exp);
			value_errors++;
		end
	endtask

	// commits must come out in line order, and never ahead of an issue
	task automatic check_commit();
		if (commit_valid !== 1'b0) begin
			if (committed >= issued) begin
				$display("a commit appeared with no instruction outstanding");
				other_errors++;
			end else begin
				check_rd(committed, commit_rd, RD_W'(field(committed, COL_RD)));
				check_value(committed, commit_value, field(committed, COL_EXPECT));
				committed++;
			end
		end
	endtask

	initial begin
		reset = 1'b0;
		hold_idle();
		$readmemh("test/alu_core_stim.txt", stim);
		// the first unloaded line reads back as unknown
		while (line_count < MAX_LINES && !$isunknown(field(line_count, COL_FUNCT3)))
			line_count++;
		if (line_count == 0) begin
			$display("the stim file holds no instructions");
			other_errors++;
		end
		for (int n = 0; n < line_count; n++) begin
			for (int col = COL_SRC1; col <= COL_SRC2; col += 2) begin
				if (field(n, col) != 0 && int'(field(n, col + 1)) >= n) begin
					$display("stim line %0d names line %0d, which is not earlier", n,
						int'(field(n, col + 1)));
					other_errors++;
				end
			end
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		// stall is a level from registers, so it already tells whether this issue lands
		while (committed < line_count) begin
			check_commit();
			if (issued < line_count) begin
				drive_line(issued);
				if (stall === 1'b0)
					issued++;
				else
					stall_seen = 1'b1;
			end else
				hold_idle();
			@(negedge clk);
		end
		// a few idle cycles to catch stray commits
		hold_idle();
		repeat (4) begin
			check_commit();
			// empty core once the last commit has retired
			check_stall(stall, 1'b0);
			@(negedge clk);
		end
		// a burst longer than the reorder buffer has to be held back somewhere
		if (line_count > ROB_SIZE && stall_seen !== 1'b1) begin
			$display("stall never rose during a burst longer than the reorder buffer");
			other_errors++;
		end
		$display("errors: %0d value, %0d other, %0d assertion; %0d of %0d lines committed",
			value_errors, other_errors, UUT.protocol_checks.fail_count, committed, line_count);
		if (value_errors + other_errors + int'(UUT.protocol_checks.fail_count) == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// budget scales with the number of stim lines
	initial begin : watchdog
		int limit;
		@(posedge reset);
		limit = (line_count + 20) * 20;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d lines committed", limit, committed,
			line_count);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/alu_core_stim.txt ====
// funct3 alt rd src1_kind src1 src2_kind src2 expected, all hex, one instruction per line
// src kind 0 means an immediate value, kind 1 means the index of an earlier line
0 0 01 0 00000005 0 00000007 0000000c
0 1 02 0 00000005 0 00000007 fffffffe
1 0 03 0 00000003 0 00000004 00000030
2 0 04 0 ffffffff 0 00000001 00000001
3 0 05 0 ffffffff 0 00000001 00000000
4 0 06 0 f0f0f0f0 0 0ff00ff0 ff00ff00
5 0 07 0 80000000 0 00000004 08000000
5 1 08 0 80000000 0 00000004 f8000000
6 0 09 0 12340000 0 00005678 12345678
7 0 0a 0 ff00ff00 0 0f0f0f0f 0f000f00
0 0 0b 1 00000008 1 00000000 12345684
0 0 0c 0 00000100 0 00000001 00000101
0 1 0d 1 0000000b 0 00000001 00000100
1 0 0e 1 0000000c 0 00000002 00000400
4 0 0f 1 0000000d 1 0000000b 00000501
6 0 10 0 00010000 0 0000000f 0001000f
0 0 11 1 0000000e 1 0000000e 00000a02
7 0 12 1 0000000f 0 0000ffff 0000000f
5 1 13 0 fffff000 1 00000011 ffffffff
3 0 14 1 00000010 1 00000012 00000001
5 0 15 1 00000012 0 00000018 000000ff
0 0 16 1 00000014 1 00000000 0000010b

// ==== files.f ====
verilog/ooo_pkg.sv
verilog/issue_route.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/common_data_bus.sv
verilog/reorder_buffer.sv
verilog/alu_core.sv
test/alu_core_assertions.sv
test/alu_core_tb.sv
